//--- hw/aud_defs.svh
`ifndef AUD_DEFS_SVH
`define AUD_DEFS_SVH

// one mono sample as stored in sram
`define AUD_SAMPLE_W 16
// sram word address, 1M words
`define AUD_ADDR_W 20

// speed code 3 plays at 1x, 0 to 2 slow down, 4 to 6 speed up
`define AUD_SPEED_NORMAL 3
`define AUD_SPEED_MAX 6

// bit clocks in one full lrck period, left plus right
`define AUD_FRAME_BCLKS 32

`endif

//--- hw/aud_sample_pkg.sv
`include "aud_defs.svh"

package aud_sample_pkg;

    // signed pcm, one word per sram location
    typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

    // unsigned word address into the sample sram
    typedef logic [`AUD_ADDR_W-1:0] sram_addr_t;

endpackage

//--- hw/aud_ctrl_pkg.sv
package aud_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_PLAY  = 2'd1,
        ST_PAUSE = 2'd2
    } play_state_e;

    typedef logic [2:0] speed_t;  // 0-2 slow, 3 normal, 4-6 fast

    // fill mode used only while playing slower than 1x
    typedef enum logic {
        INTERP_HOLD   = 1'b0,
        INTERP_LINEAR = 1'b1
    } interp_e;

endpackage

//--- hw/aud_clk_sync.sv
`timescale 1ns/1ps

module aud_clk_sync (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_aud_bclk,
    input  logic i_aud_daclrck,
    output logic o_bclk_fall,
    output logic o_bclk_rise,
    output logic o_lrck_fall,
    output logic o_lrck_rise
);

    // bit 0 carries bclk, bit 1 carries daclrck
    logic [1:0] meta_r;
    logic [1:0] sync_r;
    logic [1:0] prev_r;
    logic [1:0] rise;
    logic [1:0] fall;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            meta_r <= '0;
            sync_r <= '0;
            prev_r <= '0;
        end else begin
            meta_r <= {i_aud_daclrck, i_aud_bclk};  // first stage may go metastable
            sync_r <= meta_r;
            prev_r <= sync_r;                       // edge register
        end
    end

    // both terms come from flops so the strobes are clean single cycles
    assign rise = sync_r & ~prev_r;
    assign fall = ~sync_r & prev_r;

    assign o_bclk_rise = rise[0];
    assign o_bclk_fall = fall[0];
    assign o_lrck_rise = rise[1];   // right half-frame starts
    assign o_lrck_fall = fall[1];   // left half-frame starts

endmodule

//--- hw/aud_dsp.sv
`timescale 1ns/1ps
`include "aud_defs.svh"

module aud_dsp (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_start,
    input  logic                       i_pause,
    input  logic                       i_stop,
    input  aud_ctrl_pkg::speed_t       i_speed,
    input  aud_ctrl_pkg::interp_e      i_interp,
    input  logic                       i_lrck_fall,
    input  aud_sample_pkg::sample_t    i_sram_data,
    output aud_sample_pkg::sram_addr_t o_sram_addr,
    output aud_sample_pkg::sample_t    o_dac_data,
    output aud_ctrl_pkg::play_state_e  o_state
);

    aud_ctrl_pkg::play_state_e  state_r, state_w;
    aud_sample_pkg::sram_addr_t addr_r, addr_w;
    aud_sample_pkg::sample_t    held_r, held_w;   // sample queued for the next frame
    aud_sample_pkg::sample_t    out_r, out_w;
    logic [2:0]                 phase_r, phase_w; // c, position inside one source sample

    aud_ctrl_pkg::speed_t       speed;
    logic                       fast;
    logic [2:0]                 fast_shift;
    logic [2:0]                 slow_shift;
    logic [3:0]                 n_slow;
    logic [2:0]                 phase_last;
    aud_sample_pkg::sram_addr_t step;

    logic signed [`AUD_SAMPLE_W:0]   diff;
    logic signed [`AUD_SAMPLE_W+3:0] scaled;
    logic signed [`AUD_SAMPLE_W+3:0] interp;

    assign o_sram_addr = addr_r;
    assign o_dac_data  = out_r;
    assign o_state     = state_r;

    // codes above the table play at the fastest rate
    assign speed = (i_speed > aud_ctrl_pkg::speed_t'(`AUD_SPEED_MAX)) ?
                   aud_ctrl_pkg::speed_t'(`AUD_SPEED_MAX) : i_speed;

    assign fast       = speed >= aud_ctrl_pkg::speed_t'(`AUD_SPEED_NORMAL);
    assign fast_shift = speed - aud_ctrl_pkg::speed_t'(`AUD_SPEED_NORMAL);
    assign slow_shift = aud_ctrl_pkg::speed_t'(`AUD_SPEED_NORMAL) - speed;
    assign step       = aud_sample_pkg::sram_addr_t'(1) << fast_shift;
    assign n_slow     = 4'd1 << slow_shift;              // N frames per source sample
    assign phase_last = 3'(n_slow - 4'd1);

    // held + ((next - held) * c) >>> log2(N), kept signed all the way
    assign diff   = {i_sram_data[`AUD_SAMPLE_W-1], i_sram_data}
                  - {held_r[`AUD_SAMPLE_W-1], held_r};
    assign scaled = diff * $signed({1'b0, phase_r});
    assign interp = (scaled >>> slow_shift)
                  + $signed({{4{held_r[`AUD_SAMPLE_W-1]}}, held_r});

    always_comb begin
        state_w = state_r;
        addr_w  = addr_r;
        held_w  = held_r;
        out_w   = out_r;
        phase_w = phase_r;

        if (i_stop && state_r != aud_ctrl_pkg::ST_IDLE) begin
            state_w = aud_ctrl_pkg::ST_IDLE;
            addr_w  = '0;
            out_w   = '0;
            phase_w = '0;
        end else begin
            case (state_r)
                aud_ctrl_pkg::ST_IDLE: begin
                    if (i_start) begin
                        state_w = aud_ctrl_pkg::ST_PLAY;
                        held_w  = i_sram_data;   // address sits at 0 in idle
                        addr_w  = fast ? step : aud_sample_pkg::sram_addr_t'(1);
                        phase_w = '0;
                    end
                end
                aud_ctrl_pkg::ST_PLAY: begin
                    if (i_pause) begin
                        state_w = aud_ctrl_pkg::ST_PAUSE;
                    end else if (i_lrck_fall) begin
                        if (fast) begin
                            out_w   = held_r;
                            held_w  = i_sram_data;
                            addr_w  = addr_r + step;
                            phase_w = '0;
                        end else begin
                            out_w = (i_interp == aud_ctrl_pkg::INTERP_LINEAR) ?
                                    interp[`AUD_SAMPLE_W-1:0] : held_r;
                            if (phase_r >= phase_last) begin
                                phase_w = '0;            // move on to the next pair
                                held_w  = i_sram_data;
                                addr_w  = addr_r + aud_sample_pkg::sram_addr_t'(1);
                            end else begin
                                phase_w = phase_r + 3'd1;
                            end
                        end
                    end
                end
                aud_ctrl_pkg::ST_PAUSE: begin
                    if (!i_pause) begin
                        state_w = aud_ctrl_pkg::ST_PLAY;
                    end
                end
                default: begin
                    state_w = aud_ctrl_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= aud_ctrl_pkg::ST_IDLE;
            addr_r  <= '0;
            out_r   <= '0;
            phase_r <= '0;
        end else begin
            state_r <= state_w;
            addr_r  <= addr_w;
            out_r   <= out_w;
            phase_r <= phase_w;
        end
    end

    always_ff @(posedge i_clk) begin
        held_r <= held_w;
    end

endmodule

//--- hw/aud_dac_tx.sv
`timescale 1ns/1ps
`include "aud_defs.svh"

module aud_dac_tx (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_lrck_fall,
    input  logic                    i_lrck_rise,
    input  logic                    i_bclk_fall,
    input  aud_sample_pkg::sample_t i_sample,
    output logic                    o_aud_dacdat
);

    localparam int CNT_W = $clog2(`AUD_SAMPLE_W + 1);

    logic                     start_r;      // half-frame edge, one cycle late
    logic [`AUD_SAMPLE_W-1:0] shift_r;
    logic [CNT_W-1:0]         bits_left_r;
    logic                     shifting;

    assign shifting = i_bclk_fall && (bits_left_r != '0);

    // the delay lets the dsp finish its update before the sample is taken
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start_r <= 1'b0;
        end else begin
            start_r <= i_lrck_fall | i_lrck_rise;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bits_left_r  <= '0;
            o_aud_dacdat <= 1'b0;
        end else if (start_r) begin
            bits_left_r <= CNT_W'(`AUD_SAMPLE_W);
        end else if (i_bclk_fall) begin
            if (bits_left_r != '0) begin
                o_aud_dacdat <= shift_r[`AUD_SAMPLE_W-1];  // msb first
                bits_left_r  <= bits_left_r - CNT_W'(1);
            end else begin
                o_aud_dacdat <= 1'b0;  // pad to the end of the half-frame
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (start_r) begin
            shift_r <= i_sample;
        end else if (shifting) begin
            shift_r <= {shift_r[`AUD_SAMPLE_W-2:0], 1'b0};
        end
    end

endmodule

//--- hw/aud_player_top.sv
`timescale 1ns/1ps

module aud_player_top (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_start,
    input  logic                       i_pause,
    input  logic                       i_stop,
    input  aud_ctrl_pkg::speed_t       i_speed,
    input  aud_ctrl_pkg::interp_e      i_interp,
    input  logic                       i_aud_bclk,
    input  logic                       i_aud_daclrck,
    input  aud_sample_pkg::sample_t    i_sram_data,
    output aud_sample_pkg::sram_addr_t o_sram_addr,
    output aud_ctrl_pkg::play_state_e  o_state,
    output logic                       o_aud_dacdat
);

    logic                    bclk_fall;
    logic                    bclk_rise;  // spare strobe, the receiver edge
    logic                    lrck_fall;
    logic                    lrck_rise;
    aud_sample_pkg::sample_t dac_data;

    aud_clk_sync u_sync (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_aud_bclk    (i_aud_bclk),
        .i_aud_daclrck (i_aud_daclrck),
        .o_bclk_fall   (bclk_fall),
        .o_bclk_rise   (bclk_rise),
        .o_lrck_fall   (lrck_fall),
        .o_lrck_rise   (lrck_rise)
    );

    aud_dsp u_dsp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .i_speed     (i_speed),
        .i_interp    (i_interp),
        .i_lrck_fall (lrck_fall),
        .i_sram_data (i_sram_data),
        .o_sram_addr (o_sram_addr),
        .o_dac_data  (dac_data),
        .o_state     (o_state)
    );

    aud_dac_tx u_tx (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_lrck_fall  (lrck_fall),
        .i_lrck_rise  (lrck_rise),
        .i_bclk_fall  (bclk_fall),
        .i_sample     (dac_data),
        .o_aud_dacdat (o_aud_dacdat)
    );

endmodule

//--- sim/aud_player_asserts.sv
`timescale 1ns/1ps

module aud_player_asserts (
    input logic                      i_clk,
    input logic                      i_rst_n,
    input logic                      i_start,
    input logic                      i_aud_bclk,
    input logic                      i_aud_daclrck,
    input logic                      i_bclk_fall,
    input logic                      i_bclk_rise,
    input logic                      i_lrck_fall,
    input logic                      i_lrck_rise,
    input aud_ctrl_pkg::play_state_e i_state,
    input logic                      i_aud_dacdat
);

    logic started_r;  // set once playback has begun since reset

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            started_r <= 1'b0;
        end else if (i_state != aud_ctrl_pkg::ST_IDLE) begin
            started_r <= 1'b1;
        end
    end

    // a pin edge shows up as a single-cycle strobe three clocks later
    bclk_fall_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_aud_bclk) |-> ##2 i_bclk_fall ##1 !i_bclk_fall)
        else $error("bclk fall strobe missing, late or longer than one cycle");
    bclk_rise_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_aud_bclk) |-> ##2 i_bclk_rise ##1 !i_bclk_rise)
        else $error("bclk rise strobe missing, late or longer than one cycle");
    lrck_fall_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_aud_daclrck) |-> ##2 i_lrck_fall ##1 !i_lrck_fall)
        else $error("lrck fall strobe missing, late or longer than one cycle");
    lrck_rise_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_aud_daclrck) |-> ##2 i_lrck_rise ##1 !i_lrck_rise)
        else $error("lrck rise strobe missing, late or longer than one cycle");

    // serial line quiet until the first start
    quiet_before_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == aud_ctrl_pkg::ST_IDLE && !started_r) |-> !i_aud_dacdat)
        else $error("serial data active in idle before any start");

    idle_needs_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == aud_ctrl_pkg::ST_IDLE && !i_start) |=> i_state == aud_ctrl_pkg::ST_IDLE)
        else $error("player left idle without a start");

endmodule

//--- sim/tb_aud_player.sv
`timescale 1ns/1ps
`include "aud_defs.svh"

module tb_aud_player;

    logic                       i_clk;
    logic                       i_rst_n;
    logic                       i_start;
    logic                       i_pause;
    logic                       i_stop;
    aud_ctrl_pkg::speed_t       i_speed;
    aud_ctrl_pkg::interp_e      i_interp;
    logic                       i_aud_bclk;
    logic                       i_aud_daclrck;
    aud_sample_pkg::sample_t    i_sram_data;
    aud_sample_pkg::sram_addr_t o_sram_addr;
    aud_ctrl_pkg::play_state_e  o_state;
    logic                       o_aud_dacdat;

    aud_sample_pkg::sample_t sram [0:(1 << `AUD_ADDR_W)-1];
    logic                    rx_bits [0:4095];
    aud_sample_pkg::sample_t rx_words [$];  // left and right words in order
    int                      err_count;
    int                      check_count;

    aud_player_top u_dut (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (i_start),
        .i_pause       (i_pause),
        .i_stop        (i_stop),
        .i_speed       (i_speed),
        .i_interp      (i_interp),
        .i_aud_bclk    (i_aud_bclk),
        .i_aud_daclrck (i_aud_daclrck),
        .i_sram_data   (i_sram_data),
        .o_sram_addr   (o_sram_addr),
        .o_state       (o_state),
        .o_aud_dacdat  (o_aud_dacdat)
    );

    bind aud_player_top aud_player_asserts u_asserts (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (i_start),
        .i_aud_bclk    (i_aud_bclk),
        .i_aud_daclrck (i_aud_daclrck),
        .i_bclk_fall   (bclk_fall),
        .i_bclk_rise   (bclk_rise),
        .i_lrck_fall   (lrck_fall),
        .i_lrck_rise   (lrck_rise),
        .i_state       (o_state),
        .i_aud_dacdat  (o_aud_dacdat)
    );

    assign i_sram_data = sram[o_sram_addr];  // asynchronous sram read

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial begin
        #5ms;
        $display("simulation did not finish within the time limit");
        $display("Some tests failed");
        $finish;
    end

    task automatic check_sample(string name, aud_sample_pkg::sample_t got,
                                aud_sample_pkg::sample_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(aud_sample_pkg::sram_addr_t got, aud_sample_pkg::sram_addr_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR o_sram_addr got %h expected %h", got, exp);
        end
    endtask

    task automatic check_state(aud_ctrl_pkg::play_state_e got, aud_ctrl_pkg::play_state_e exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR o_state got %h expected %h", got, exp);
        end
    endtask

    // output of left frame k from the speed rule
    function automatic aud_sample_pkg::sample_t expected_sample(int k, int speed,
                                                                aud_ctrl_pkg::interp_e mode);
        int     step;
        int     n;
        int     j;
        int     c;
        longint a;
        longint b;
        longint v;
        if (speed >= `AUD_SPEED_NORMAL) begin
            step = 1 << (speed - `AUD_SPEED_NORMAL);
            return sram[aud_sample_pkg::sram_addr_t'(k * step)];
        end
        n = 1 << (`AUD_SPEED_NORMAL - speed);
        j = k / n;
        c = k % n;
        a = longint'(sram[aud_sample_pkg::sram_addr_t'(j)]);
        b = longint'(sram[aud_sample_pkg::sram_addr_t'(j + 1)]);
        if (mode == aud_ctrl_pkg::INTERP_HOLD) begin
            return aud_sample_pkg::sample_t'(a);
        end
        v = a + (((b - a) * c) >>> (`AUD_SPEED_NORMAL - speed));  // floors for negatives
        return aud_sample_pkg::sample_t'(v);
    endfunction

    task automatic wait_for_state(aud_ctrl_pkg::play_state_e st);
        int  i;
        bit  seen;
        seen = 1'b0;
        for (i = 0; i < 100 && !seen; i++) begin
            @(posedge i_clk);
            seen = (o_state == st);
        end
        if (!seen) begin
            err_count++;
            $display("timed out waiting for player state %s", st.name());
        end
    endtask

    // codec model, drives n frames and captures the serial line on bclk rises
    task automatic play_frames(int n);
        int               h;
        int               b;
        int               r;
        int               i;
        logic [15:0]      w;
        r = 0;
        rx_words.delete();
        for (h = 0; h < 2 * n; h++) begin
            for (b = 0; b < `AUD_FRAME_BCLKS / 2; b++) begin
                @(posedge i_clk);
                i_aud_bclk <= 1'b0;
                if (b == 0) begin
                    i_aud_daclrck <= h[0];  // low for left, high for right
                end
                repeat (3) @(posedge i_clk);
                @(posedge i_clk);
                i_aud_bclk <= 1'b1;
                rx_bits[r] = o_aud_dacdat;
                r++;
                repeat (3) @(posedge i_clk);
            end
        end
        @(posedge i_clk);  // one more bit clock carries the last lsb
        i_aud_bclk <= 1'b0;
        repeat (4) @(posedge i_clk);
        i_aud_bclk <= 1'b1;
        rx_bits[r] = o_aud_dacdat;
        repeat (4) @(posedge i_clk);
        for (h = 0; h < 2 * n; h++) begin
            w = '0;
            for (i = 1; i <= `AUD_SAMPLE_W; i++) begin
                w = {w[14:0], rx_bits[h * 16 + i]};
            end
            rx_words.push_back(aud_sample_pkg::sample_t'(w));
        end
    endtask

    task automatic start_playback(int speed, aud_ctrl_pkg::interp_e mode);
        @(posedge i_clk);
        i_speed  <= aud_ctrl_pkg::speed_t'(speed);
        i_interp <= mode;
        i_start  <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        wait_for_state(aud_ctrl_pkg::ST_PLAY);
    endtask

    task automatic stop_playback();
        @(posedge i_clk);
        i_stop <= 1'b1;
        @(posedge i_clk);
        i_stop <= 1'b0;
        wait_for_state(aud_ctrl_pkg::ST_IDLE);
        check_addr(o_sram_addr, '0);
    endtask

    // compares captured words against frames k0 onward
    task automatic compare_frames(int k0, int speed, aud_ctrl_pkg::interp_e mode);
        int i;
        for (i = 0; i < rx_words.size(); i++) begin
            check_sample("o_aud_dacdat word", rx_words[i],
                         expected_sample(k0 + i / 2, speed, mode));
        end
    endtask

    task automatic idle_after_reset();
        int i;
        check_state(o_state, aud_ctrl_pkg::ST_IDLE);
        check_addr(o_sram_addr, '0);
        play_frames(1);
        for (i = 0; i < rx_words.size(); i++) begin
            check_sample("o_aud_dacdat idle word", rx_words[i], '0);
        end
    endtask

    task automatic play_at_speed(int speed, aud_ctrl_pkg::interp_e mode, int frames);
        start_playback(speed, mode);
        play_frames(frames);
        compare_frames(0, speed, mode);
        stop_playback();
    endtask

    task automatic pause_and_resume();
        aud_sample_pkg::sram_addr_t held_addr;
        int                         i;
        start_playback(4, aud_ctrl_pkg::INTERP_HOLD);
        play_frames(3);
        compare_frames(0, 4, aud_ctrl_pkg::INTERP_HOLD);
        @(posedge i_clk);
        i_pause <= 1'b1;
        wait_for_state(aud_ctrl_pkg::ST_PAUSE);
        held_addr = aud_sample_pkg::sram_addr_t'((1 + 3) * 2);  // start step plus three frames
        check_addr(o_sram_addr, held_addr);
        play_frames(2);
        for (i = 0; i < rx_words.size(); i++) begin
            check_sample("o_aud_dacdat paused word", rx_words[i],
                         expected_sample(2, 4, aud_ctrl_pkg::INTERP_HOLD));
        end
        check_addr(o_sram_addr, held_addr);
        @(posedge i_clk);
        i_pause <= 1'b0;
        wait_for_state(aud_ctrl_pkg::ST_PLAY);
        play_frames(3);
        compare_frames(3, 4, aud_ctrl_pkg::INTERP_HOLD);  // k picks up where it froze
        stop_playback();
    endtask

    task automatic stop_and_restart();
        int i;
        start_playback(`AUD_SPEED_NORMAL, aud_ctrl_pkg::INTERP_HOLD);
        play_frames(2);
        compare_frames(0, `AUD_SPEED_NORMAL, aud_ctrl_pkg::INTERP_HOLD);
        stop_playback();
        play_frames(1);
        check_state(o_state, aud_ctrl_pkg::ST_IDLE);  // frames alone never restart it
        for (i = 0; i < rx_words.size(); i++) begin
            check_sample("o_aud_dacdat stopped word", rx_words[i], '0);
        end
        play_at_speed(`AUD_SPEED_NORMAL, aud_ctrl_pkg::INTERP_HOLD, 2);
    endtask

    initial begin
        int i;
        err_count     = 0;
        check_count   = 0;
        i_rst_n       = 1'b0;
        i_start       = 1'b0;
        i_pause       = 1'b0;
        i_stop        = 1'b0;
        i_speed       = aud_ctrl_pkg::speed_t'(`AUD_SPEED_NORMAL);
        i_interp      = aud_ctrl_pkg::INTERP_HOLD;
        i_aud_bclk    = 1'b1;  // codec idles with both clocks high
        i_aud_daclrck = 1'b1;
        void'($urandom(32'hac14_aa38));
        for (i = 0; i < (1 << `AUD_ADDR_W); i++) begin
            sram[i] = aud_sample_pkg::sample_t'($urandom);
        end
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);

        idle_after_reset();
        for (i = 3; i <= `AUD_SPEED_MAX; i++) begin
            play_at_speed(i, aud_ctrl_pkg::INTERP_HOLD, 6);
        end
        for (i = 0; i < 3; i++) begin
            play_at_speed(i, aud_ctrl_pkg::INTERP_HOLD, 10);
        end
        sram[0] = 16'sh7ff0;    // large falling and rising steps
        sram[1] = -16'sh7ffd;
        sram[2] = 16'sh0123;
        sram[3] = -16'sh0007;
        for (i = 0; i < 3; i++) begin
            play_at_speed(i, aud_ctrl_pkg::INTERP_LINEAR, 10);
        end
        pause_and_resume();
        stop_and_restart();

        $display("checks %0d errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+hw
hw/aud_sample_pkg.sv
hw/aud_ctrl_pkg.sv
hw/aud_clk_sync.sv
hw/aud_dsp.sv
hw/aud_dac_tx.sv
hw/aud_player_top.sv
sim/aud_player_asserts.sv
sim/tb_aud_player.sv

//--- run.sh
#!/bin/sh
# Build and run the audio player testbench with Verilator.
# The run fails when a command fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_aud_player -o tb_aud_player
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/tb_aud_player > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
